/* Makefile */
TOP  := soc_io_tb
SRCS := $(shell cat vlog.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* hw/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import mmio_types_pkg::*;
#(
    parameter int ram_words = 512
) (
    input  wire logic                  clk,
    input  wire logic [addr_width-1:0] mem_raddr,
    input  wire logic [addr_width-1:0] mem_waddr,
    input  wire logic [data_width-1:0] mem_wdata,
    input  wire logic                  ram_wen,
    input  wire wdt_op_e               wdt_op,
    output logic      [data_width-1:0] ram_rdata
);

    localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;
    localparam int lanes = data_width / 8;

    // doubleword storage, no reset
    logic [data_width-1:0] mem [ram_words];

    logic [idx_w-1:0]      rd_idx;
    logic [idx_w-1:0]      wr_idx;
    logic [2:0]            wr_off;
    logic [lanes-1:0]      wr_be;
    logic [data_width-1:0] wr_data;

    // index from bits above the byte offset
    assign rd_idx = mem_raddr[idx_w+2:3];
    assign wr_idx = mem_waddr[idx_w+2:3];
    assign wr_off = mem_waddr[2:0];

    // async read, old data on same-cycle write
    assign ram_rdata = mem[rd_idx];

    // byte enables per write type, shifted to the lane offset
    always_comb begin
        case (wdt_op)
            wdt_byte:   wr_be = 8'h01 << wr_off;
            wdt_half:   wr_be = 8'h03 << wr_off;
            wdt_word:   wr_be = 8'h0f << wr_off;
            default:    wr_be = 8'hff;
        endcase
    end

    // low lanes of store data moved up to the offset
    assign wr_data = (wdt_op == wdt_double) ? mem_wdata : (mem_wdata << {wr_off, 3'b000});

    // lane merge
    always_ff @(posedge clk) begin
        if (ram_wen) begin
            for (int i = 0; i < lanes; i++) begin
                if (wr_be[i]) begin
                    mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/kbd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module kbd_fifo
    import mmio_types_pkg::*;
#(
    parameter int kbd_depth = 4
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [kb_width-1:0] kb_code,
    input  wire logic                kb_strobe,
    input  wire logic                sig_rd_kb,
    output logic      [kb_width-1:0] kb_rdata,
    output logic                     kb_ready
);

    localparam int ptr_w = (kbd_depth > 1) ? $clog2(kbd_depth) : 1;
    localparam int cnt_w = $clog2(kbd_depth + 1);

    // scan code storage
    logic [kb_width-1:0] buf_q [kbd_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full     = (count == cnt_w'(kbd_depth));
    assign kb_ready = (count != '0);
    assign kb_rdata = buf_q[rd_ptr];

    // strobe into a full buffer is dropped
    assign push = kb_strobe && !full;
    assign pop  = sig_rd_kb && kb_ready;

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(kbd_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(kbd_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry write
    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr] <= kb_code;
        end
    end

endmodule

`default_nettype wire

/* hw/mmio.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio
    import mmio_types_pkg::*, mmio_map_pkg::*;
#(
    parameter int ram_words = 512
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [addr_width-1:0] mem_raddr,
    input  wire logic                  mem_ren,
    input  wire logic [addr_width-1:0] mem_waddr,
    input  wire logic                  mem_wen,
    input  wire logic [data_width-1:0] mem_wdata,
    input  wire logic [data_width-1:0] ram_rdata,
    input  wire logic [kb_width-1:0]   kb_rdata,
    input  wire logic                  kb_ready,
    input  wire logic [swt_width-1:0]  swt,
    input  wire logic [tick_width-1:0] ticks,
    output logic      [data_width-1:0] mem_rdata,
    output logic                       ram_wen,
    output logic                       sig_rd_kb,
    output logic      [seg_width-1:0]  seg_out,
    output logic      [led_width-1:0]  led_out,
    output logic                       addr_fault
);

    // physical ram size in bytes
    localparam int unsigned ram_bytes = ram_words * 8;

    // read target select
    typedef enum logic [2:0] {
        sel_none, sel_ram, sel_kbd, sel_swt, sel_rtc
    } rd_sel_e;

    rd_sel_e               rd_sel;
    logic [data_width-1:0] rd_data;
    logic                  wr_ram;
    logic                  wr_seg;
    logic                  wr_led;
    logic                  wr_serial;
    logic                  wr_mapped;

    // unsigned offset compare, no wrap past the top of the space
    function automatic logic in_win(input logic [addr_width-1:0] addr,
                                    input logic [addr_width-1:0] base,
                                    input int unsigned len);
        logic [addr_width-1:0] off;
        off = addr - base;
        return (addr >= base) && (off < addr_width'(len));
    endfunction

    // read decode
    always_comb begin
        if (in_win(mem_raddr, ram_base, ram_len) && in_win(mem_raddr, ram_base, ram_bytes)) begin
            rd_sel = sel_ram;
        end else if (in_win(mem_raddr, kbd_base, kbd_len)) begin
            rd_sel = sel_kbd;
        end else if (in_win(mem_raddr, swt_base, peri_len)) begin
            rd_sel = sel_swt;
        end else if (in_win(mem_raddr, rtc_base, rtc_len)) begin
            rd_sel = sel_rtc;
        end else begin
            rd_sel = sel_none;
        end
    end

    // read data mux, zero when not reading
    always_comb begin
        rd_data = '0;
        if (mem_ren) begin
            case (rd_sel)
                sel_ram: rd_data = ram_rdata;
                // empty buffer reads as zero
                sel_kbd: rd_data = kb_ready ? {{(data_width-kb_width){1'b0}}, kb_rdata} : '0;
                sel_swt: rd_data = {{(data_width-swt_width){1'b0}}, swt};
                sel_rtc: rd_data = {{(data_width-tick_width){1'b0}}, ticks};
                default: rd_data = '0;
            endcase
        end
    end

    // pop at the read edge, head captured at the same edge
    assign sig_rd_kb = mem_ren && (rd_sel == sel_kbd) && kb_ready;

    // write decode
    assign wr_ram    = in_win(mem_waddr, ram_base, ram_len) && in_win(mem_waddr, ram_base, ram_bytes);
    assign wr_seg    = in_win(mem_waddr, seg_base, peri_len);
    assign wr_led    = in_win(mem_waddr, led_base, peri_len);
    assign wr_serial = in_win(mem_waddr, serial_base, serial_len);
    // serial writes count as mapped
    assign wr_mapped = wr_ram || wr_seg || wr_led || wr_serial;

    assign ram_wen = mem_wen && wr_ram;

    // registered read data, seg and led registers, fault pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rdata  <= '0;
            seg_out    <= '0;
            led_out    <= '0;
            addr_fault <= 1'b0;
        end else begin
            mem_rdata  <= rd_data;
            addr_fault <= (mem_ren && (rd_sel == sel_none)) || (mem_wen && !wr_mapped);
            if (mem_wen && wr_seg) begin
                // new byte enters at the low end
                seg_out <= {seg_out[seg_width-9:0], mem_wdata[7:0]};
            end
            if (mem_wen && wr_led) begin
                led_out <= mem_wdata[led_width-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mmio_map_pkg.sv */
`default_nettype none

// address map of the io space
package mmio_map_pkg;

    import mmio_types_pkg::*;

    // data ram window
    parameter logic [addr_width-1:0] ram_base = 32'h8000_0000;
    parameter int unsigned           ram_len  = 4096;

    // keyboard scan code buffer
    parameter logic [addr_width-1:0] kbd_base = 32'h1000_0000;
    parameter int unsigned           kbd_len  = 8;

    // board peripherals, one doubleword each
    parameter logic [addr_width-1:0] swt_base = 32'h1000_0008;
    parameter logic [addr_width-1:0] seg_base = 32'h1000_0010;
    parameter logic [addr_width-1:0] led_base = 32'h1000_0018;
    parameter int unsigned           peri_len = 8;

    // tick counter used as rtc
    parameter logic [addr_width-1:0] rtc_base = 32'h1000_0020;
    parameter int unsigned           rtc_len  = 8;

    // serial port, writes dropped
    parameter logic [addr_width-1:0] serial_base = 32'h1000_0100;
    parameter int unsigned           serial_len  = 8;

endpackage

`default_nettype wire

/* hw/mmio_types_pkg.sv */
`default_nettype none

// widths shared by the mmio block and its targets
package mmio_types_pkg;

    // cpu data path
    parameter int data_width = 64;
    parameter int addr_width = 32;

    // peripheral widths
    parameter int kb_width   = 8;
    parameter int seg_width  = 32;
    parameter int led_width  = 16;
    parameter int swt_width  = 8;
    parameter int tick_width = 32;

    // write data type from the cpu store
    // lanes picked by addr[2:0], data taken from the low lanes
    typedef enum logic [1:0] {
        wdt_byte   = 2'd0,
        wdt_half   = 2'd1,
        wdt_word   = 2'd2,
        wdt_double = 2'd3
    } wdt_op_e;

endpackage

`default_nettype wire

/* hw/soc_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_io_top
    import mmio_types_pkg::*;
#(
    parameter int ram_words = 512,
    parameter int kbd_depth = 4,
    parameter int tick_div  = 4
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // cpu side
    input  wire logic [addr_width-1:0] mem_raddr,
    input  wire logic                  mem_ren,
    input  wire logic [addr_width-1:0] mem_waddr,
    input  wire logic                  mem_wen,
    input  wire logic [data_width-1:0] mem_wdata,
    input  wire wdt_op_e               wdt_op,
    output logic      [data_width-1:0] mem_rdata,
    // board side
    input  wire logic [kb_width-1:0]   kb_code,
    input  wire logic                  kb_strobe,
    input  wire logic [swt_width-1:0]  swt,
    output logic      [seg_width-1:0]  seg_out,
    output logic      [led_width-1:0]  led_out,
    output logic                       addr_fault
);

    logic [data_width-1:0] ram_rdata;
    logic                  ram_wen;
    logic [kb_width-1:0]   kb_rdata;
    logic                  kb_ready;
    logic                  sig_rd_kb;
    logic [tick_width-1:0] ticks;

    // decoder and peripheral registers
    mmio #(
        .ram_words(ram_words)
    ) u_mmio (
        .clk       (clk),
        .reset     (reset),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .mem_waddr (mem_waddr),
        .mem_wen   (mem_wen),
        .mem_wdata (mem_wdata),
        .ram_rdata (ram_rdata),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .swt       (swt),
        .ticks     (ticks),
        .mem_rdata (mem_rdata),
        .ram_wen   (ram_wen),
        .sig_rd_kb (sig_rd_kb),
        .seg_out   (seg_out),
        .led_out   (led_out),
        .addr_fault(addr_fault)
    );

    data_ram #(
        .ram_words(ram_words)
    ) u_data_ram (
        .clk      (clk),
        .mem_raddr(mem_raddr),
        .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata),
        .ram_wen  (ram_wen),
        .wdt_op   (wdt_op),
        .ram_rdata(ram_rdata)
    );

    // scan codes from the board
    kbd_fifo #(
        .kbd_depth(kbd_depth)
    ) u_kbd_fifo (
        .clk      (clk),
        .reset    (reset),
        .kb_code  (kb_code),
        .kb_strobe(kb_strobe),
        .sig_rd_kb(sig_rd_kb),
        .kb_rdata (kb_rdata),
        .kb_ready (kb_ready)
    );

    // rtc source
    tick_counter #(
        .tick_div(tick_div)
    ) u_tick_counter (
        .clk  (clk),
        .reset(reset),
        .ticks(ticks)
    );

endmodule

`default_nettype wire

/* hw/tick_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_counter
    import mmio_types_pkg::*;
#(
    parameter int tick_div = 4
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output logic      [tick_width-1:0] ticks
);

    localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [div_w-1:0] prescale;
    logic             wrap;

    // last cycle of each tick period
    assign wrap = (prescale == div_w'(tick_div - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale <= '0;
            ticks    <= '0;
        end else begin
            if (wrap) begin
                prescale <= '0;
                ticks    <= ticks + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/mmio_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_props
    import mmio_types_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  reset,
    input wire logic                  mem_ren,
    input wire logic                  mem_wen,
    input wire logic [data_width-1:0] mem_rdata,
    input wire logic                  sig_rd_kb,
    input wire logic                  kb_ready,
    input wire logic                  addr_fault
);

    // read bus idles at zero
    rdata_zero_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        !mem_ren |=> (mem_rdata == '0)
    ) else $error("mem_rdata nonzero one cycle after no read");

    // pop only from a buffer holding a code
    pop_needs_ready: assert property (
        @(posedge clk) disable iff (reset)
        sig_rd_kb |-> kb_ready
    ) else $error("sig_rd_kb high while kb_ready low");

    // fault is a pulse once the bus goes quiet
    fault_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        (addr_fault && !mem_ren && !mem_wen) |=> !addr_fault
    ) else $error("addr_fault held past one cycle");

endmodule

`default_nettype wire

/* verification/soc_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_io_tb
    import mmio_types_pkg::*, mmio_map_pkg::*;
();

    localparam int ram_words  = 512;
    localparam int kbd_depth  = 4;
    localparam int tick_div   = 4;
    localparam int n_tests    = 6;
    localparam int rtc_gap    = 40;
    localparam int poll_limit = 4 * tick_div + 4;

    typedef enum logic [2:0] {op_wr, op_rd, op_key, op_seg, op_led} op_e;

    // one table row with its expected values
    typedef struct packed {
        op_e                   op;
        int                    test;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        wdt_op_e               wdt;
        logic [data_width-1:0] exp_data;
        logic                  exp_fault;
    } entry_t;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] mem_raddr;
    logic                  mem_ren;
    logic [addr_width-1:0] mem_waddr;
    logic                  mem_wen;
    logic [data_width-1:0] mem_wdata;
    wdt_op_e               wdt_op;
    logic [data_width-1:0] mem_rdata;
    logic [kb_width-1:0]   kb_code;
    logic                  kb_strobe;
    logic [swt_width-1:0]  swt;
    logic [seg_width-1:0]  seg_out;
    logic [led_width-1:0]  led_out;
    logic                  addr_fault;

    entry_t                tbl[$];
    // shadow of ram contents per doubleword
    logic [data_width-1:0] shadow [ram_words];
    logic [seg_width-1:0]  seg_model;
    logic [led_width-1:0]  led_model;
    logic [swt_width-1:0]  swt_val;
    logic [31:0]           lfsr;
    int                    errors;
    int                    test_err [n_tests];
    string                 test_name [n_tests];
    bit                    timed_out;

    soc_io_top #(
        .ram_words(ram_words),
        .kbd_depth(kbd_depth),
        .tick_div (tick_div)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .mem_waddr (mem_waddr),
        .mem_wen   (mem_wen),
        .mem_wdata (mem_wdata),
        .wdt_op    (wdt_op),
        .mem_rdata (mem_rdata),
        .kb_code   (kb_code),
        .kb_strobe (kb_strobe),
        .swt       (swt),
        .seg_out   (seg_out),
        .led_out   (led_out),
        .addr_fault(addr_fault)
    );

    bind mmio mmio_props u_mmio_props (
        .clk       (clk),
        .reset     (reset),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_rdata (mem_rdata),
        .sig_rd_kb (sig_rd_kb),
        .kb_ready  (kb_ready),
        .addr_fault(addr_fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [data_width-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[data_width-2:0], lfsr[0]};
        end
    endtask

    task automatic note_error(input int test);
        errors++;
        test_err[test]++;
    endtask

    task automatic add_entry(input op_e op, input int test,
                             input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] data, input wdt_op_e wdt,
                             input logic [data_width-1:0] exp_data, input logic exp_fault);
        entry_t e;
        e.op        = op;
        e.test      = test;
        e.addr      = addr;
        e.data      = data;
        e.wdt       = wdt;
        e.exp_data  = exp_data;
        e.exp_fault = exp_fault;
        tbl.push_back(e);
    endtask

    // size from the type and lanes from addr[2:0] with data from the low bytes
    task automatic shadow_store(input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] data, input wdt_op_e wdt);
        int idx;
        int off;
        int nbytes;
        idx = int'(addr[11:3]);
        off = int'(addr[2:0]);
        case (wdt)
            wdt_byte: nbytes = 1;
            wdt_half: nbytes = 2;
            wdt_word: nbytes = 4;
            default:  nbytes = 8;
        endcase
        for (int i = 0; i < nbytes; i++) begin
            if (off + i < 8) begin
                shadow[idx][(off + i) * 8 +: 8] = data[i * 8 +: 8];
            end
        end
    endtask

    task automatic ram_store(input logic [addr_width-1:0] addr, input wdt_op_e wdt);
        logic [data_width-1:0] d;
        rand_bits(data_width, d);
        shadow_store(addr, d, wdt);
        add_entry(op_wr, 0, addr, d, wdt, '0, 1'b0);
    endtask

    task automatic ram_load(input int test, input logic [addr_width-1:0] addr);
        add_entry(op_rd, test, addr, '0, wdt_double, shadow[int'(addr[11:3])], 1'b0);
    endtask

    task automatic build_table();
        logic [data_width-1:0] r;
        logic [kb_width-1:0]   code;
        // all ram write types at several offsets
        ram_store(ram_base + 32'h0, wdt_double);
        ram_store(ram_base + 32'h3, wdt_byte);
        ram_store(ram_base + 32'h6, wdt_half);
        ram_store(ram_base + 32'h8, wdt_double);
        ram_store(ram_base + 32'hc, wdt_word);
        ram_store(ram_base + 32'h9, wdt_byte);
        ram_store(ram_base + 32'h10, wdt_double);
        ram_store(ram_base + 32'h10, wdt_word);
        ram_store(ram_base + 32'hff8, wdt_double);
        ram_store(ram_base + 32'hffa, wdt_half);
        ram_load(0, ram_base + 32'h0);
        ram_load(0, ram_base + 32'h8);
        ram_load(0, ram_base + 32'h10);
        ram_load(0, ram_base + 32'hff8);
        // segments shift in a1 b2 c3 under random upper data
        for (int i = 0; i < 3; i++) begin
            code = 8'ha1 + 8'(17 * i);
            rand_bits(data_width, r);
            // each byte enters at the low end and pushes the older ones up
            seg_model = (seg_model << 8) | seg_width'(code);
            add_entry(op_wr, 1, seg_base, {r[data_width-1:8], code}, wdt_double, '0, 1'b0);
        end
        add_entry(op_seg, 1, '0, '0, wdt_double, data_width'(seg_model), 1'b0);
        rand_bits(data_width, r);
        led_model = r[led_width-1:0];
        add_entry(op_wr, 1, led_base, r, wdt_double, '0, 1'b0);
        add_entry(op_led, 1, '0, '0, wdt_double, data_width'(led_model), 1'b0);
        // two keys give two codes and then an empty read
        add_entry(op_key, 2, '0, 64'h1c, wdt_double, '0, 1'b0);
        add_entry(op_key, 2, '0, 64'h32, wdt_double, '0, 1'b0);
        add_entry(op_rd, 2, kbd_base, '0, wdt_double, 64'h1c, 1'b0);
        add_entry(op_rd, 2, kbd_base, '0, wdt_double, 64'h32, 1'b0);
        add_entry(op_rd, 2, kbd_base, '0, wdt_double, '0, 1'b0);
        // one key more than the buffer holds so the last one is lost
        for (int i = 0; i <= kbd_depth; i++) begin
            add_entry(op_key, 2, '0, 64'h41 + 64'(i), wdt_double, '0, 1'b0);
        end
        for (int i = 0; i < kbd_depth; i++) begin
            add_entry(op_rd, 2, kbd_base, '0, wdt_double, 64'h41 + 64'(i), 1'b0);
        end
        add_entry(op_rd, 2, kbd_base, '0, wdt_double, '0, 1'b0);
        // switches
        rand_bits(swt_width, r);
        swt_val = r[swt_width-1:0];
        add_entry(op_rd, 3, swt_base, '0, wdt_double, data_width'(swt_val), 1'b0);
        // unmapped read and writes and then a serial write
        rand_bits(data_width, r);
        add_entry(op_rd, 4, 32'h2000_0000, '0, wdt_double, '0, 1'b1);
        add_entry(op_wr, 4, 32'h3000_0000, r, wdt_double, '0, 1'b1);
        // first byte past the ram window would alias word 0 if decoded wrong
        add_entry(op_wr, 4, ram_base + 32'h1000, r, wdt_double, '0, 1'b1);
        ram_load(4, ram_base);
        add_entry(op_wr, 4, serial_base, r, wdt_double, '0, 1'b0);
        add_entry(op_seg, 4, '0, '0, wdt_double, data_width'(seg_model), 1'b0);
        add_entry(op_led, 4, '0, '0, wdt_double, data_width'(led_model), 1'b0);
    endtask

    task automatic check_fault(input entry_t e);
        if (addr_fault !== e.exp_fault) begin
            $display("MISMATCH at %0t: addr_fault %b after access to 0x%08h, expected %b",
                     $time, addr_fault, e.addr, e.exp_fault);
            note_error(e.test);
        end
    endtask

    // inputs change 1 ns after the edge and results are read 1 ns after the next
    task automatic apply_entry(input entry_t e);
        case (e.op)
            op_wr: begin
                mem_waddr = e.addr;
                mem_wdata = e.data;
                wdt_op    = e.wdt;
                mem_wen   = 1'b1;
                @(posedge clk);
                #1;
                mem_wen = 1'b0;
                check_fault(e);
            end
            op_rd: begin
                mem_raddr = e.addr;
                mem_ren   = 1'b1;
                @(posedge clk);
                #1;
                mem_ren = 1'b0;
                if (mem_rdata !== e.exp_data) begin
                    $display("MISMATCH at %0t: read of 0x%08h gave 0x%016h, expected 0x%016h",
                             $time, e.addr, mem_rdata, e.exp_data);
                    note_error(e.test);
                end
                check_fault(e);
            end
            op_key: begin
                kb_code   = e.data[kb_width-1:0];
                kb_strobe = 1'b1;
                @(posedge clk);
                #1;
                kb_strobe = 1'b0;
            end
            op_seg: begin
                if (seg_out !== e.exp_data[seg_width-1:0]) begin
                    $display("MISMATCH at %0t: seg_out 0x%08h, expected 0x%08h",
                             $time, seg_out, e.exp_data[seg_width-1:0]);
                    note_error(e.test);
                end
            end
            default: begin
                if (led_out !== e.exp_data[led_width-1:0]) begin
                    $display("MISMATCH at %0t: led_out 0x%04h, expected 0x%04h",
                             $time, led_out, e.exp_data[led_width-1:0]);
                    note_error(e.test);
                end
            end
        endcase
        // idle cycle keeps fault pulses apart
        if (e.op != op_seg && e.op != op_led) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input int id);
        if (test_err[id] == 0) begin
            $display("test %0d (%s) passed", id, test_name[id]);
        end else begin
            $display("test %0d (%s) failed, %0d errors", id, test_name[id], test_err[id]);
        end
    endtask

    task automatic run_table();
        int cur;
        cur = tbl[0].test;
        foreach (tbl[i]) begin
            if (tbl[i].test != cur) begin
                report_test(cur);
                cur = tbl[i].test;
            end
            apply_entry(tbl[i]);
        end
        report_test(cur);
    endtask

    // reads run back to back without an idle cycle
    task automatic rtc_read(output logic [data_width-1:0] v);
        mem_raddr = rtc_base;
        mem_ren   = 1'b1;
        @(posedge clk);
        #1;
        mem_ren = 1'b0;
        v       = mem_rdata;
        if (v[data_width-1:tick_width] != '0 || addr_fault !== 1'b0) begin
            $display("MISMATCH at %0t: rtc read 0x%016h with fault %b", $time, v, addr_fault);
            note_error(5);
        end
    endtask

    task automatic rtc_test();
        logic [data_width-1:0] first;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        int                    tries;
        int                    diff;
        rtc_read(first);
        a     = first;
        tries = 0;
        // align on a tick change
        while (a == first && tries < poll_limit) begin
            rtc_read(a);
            tries++;
        end
        if (a == first) begin
            $display("TIMEOUT at %0t: rtc did not advance in %0d reads", $time, poll_limit);
            timed_out = 1'b1;
            note_error(5);
            return;
        end
        // second read sampled rtc_gap edges after the first
        repeat (rtc_gap - 1) @(posedge clk);
        #1;
        rtc_read(b);
        diff = int'(b[31:0] - a[31:0]);
        if (diff < rtc_gap / tick_div - 1 || diff > rtc_gap / tick_div + 1) begin
            $display("MISMATCH at %0t: rtc advanced %0d over %0d cycles, expected %0d +-1",
                     $time, diff, rtc_gap, rtc_gap / tick_div);
            note_error(5);
        end
    endtask

    initial begin
        int passed;
        reset     = 1'b1;
        mem_raddr = '0;
        mem_ren   = 1'b0;
        mem_waddr = '0;
        mem_wen   = 1'b0;
        mem_wdata = '0;
        wdt_op    = wdt_byte;
        kb_code   = '0;
        kb_strobe = 1'b0;
        swt       = '0;
        lfsr      = 32'h73e6;
        seg_model = '0;
        led_model = '0;
        errors    = 0;
        timed_out = 1'b0;
        foreach (test_err[i]) test_err[i] = 0;
        test_name[0] = "ram lanes";
        test_name[1] = "seg and led";
        test_name[2] = "keyboard";
        test_name[3] = "switches";
        test_name[4] = "faults";
        test_name[5] = "rtc";
        build_table();
        swt = swt_val;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        run_table();
        rtc_test();
        report_test(5);
        passed = 0;
        foreach (test_err[i]) begin
            if (test_err[i] == 0) passed++;
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors, timeout %0b",
                 n_tests, passed, n_tests - passed, errors, timed_out);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/mmio_types_pkg.sv
hw/mmio_map_pkg.sv
hw/data_ram.sv
hw/kbd_fifo.sv
hw/tick_counter.sv
hw/mmio.sv
hw/soc_io_top.sv
verification/mmio_props.sv
verification/soc_io_tb.sv
